// ==== hdl/rv32_pkg.sv ====
/*
 * rv32 shared types
 * opcodes, alu operations, instruction format views and the control,
 * retire and data request records of the core
 */
package rv32_pkg;

    typedef enum logic [6:0] {
        RTYPE  = 7'b0110011,
        ITYPEL = 7'b0000011,
        ITYPER = 7'b0010011,
        STYPE  = 7'b0100011,
        UTYPE  = 7'b0110111,
        SBTYPE = 7'b1100011,
        ITYPEJ = 7'b1100111,
        JTYPE  = 7'b1101111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // {bit30, funct3}
    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000,
        ALU_SUB = 4'b1000,
        ALU_SLL = 4'b0001,
        ALU_SLT = 4'b0010,
        ALU_XOR = 4'b0100,
        ALU_SRL = 4'b0101,
        ALU_SRA = 4'b1101,
        ALU_OR  = 4'b0110,
        ALU_AND = 4'b0111,
        ALU_LUI = 4'b0011,
        ALU_NOP = 4'b1111
    } alu_op_e;

    typedef enum logic [1:0] {
        WIDTH_B = 2'b00,
        WIDTH_H = 2'b01,
        WIDTH_W = 2'b10
    } width_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'b000,
        BR_EQ   = 3'b100,
        BR_NE   = 3'b101,
        BR_LT   = 3'b110,
        BR_GE   = 3'b111
    } branch_e;

    typedef enum logic [1:0] {
        JMP_NONE = 2'b00,
        JMP_JAL  = 2'b01,
        JMP_JALR = 2'b10
    } jump_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        width_e  width;
        jump_e   jump;
        branch_e branch;
        logic    mem_read;
        logic    mem_to_reg;
        logic    mem_write;
        logic    alu_src;    // operand b from immediate
        logic    reg_write;
        logic    auipc;      // operand a from pc
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic        we;
    } retire_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic        read;
        logic        write;
    } dmem_req_t;

endpackage

// ==== hdl/control_unit.sv ====
/*
 * control_unit
 * decodes opcode, funct3 and bit 30 into the control record
 */
`timescale 1ns/1ns

module control_unit import rv32_pkg::*; (
    input  opcode_e    opcode,
    input  logic [2:0] funct3,
    input  logic       bit30,
    output ctrl_t      ctrl
);

    // shared by register and immediate arithmetic
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            3'b111:  op = ALU_AND;
            default: op = ALU_NOP; // sltu not supported
        endcase
        return op;
    endfunction

    function automatic width_e mem_width(input logic [2:0] f3);
        width_e w;
        case (f3)
            3'b000:  w = WIDTH_B;
            3'b001:  w = WIDTH_H;
            default: w = WIDTH_W;
        endcase
        return w;
    endfunction

    always_comb begin
        // everything off, then enable per opcode
        ctrl.width      = WIDTH_W;
        ctrl.jump       = JMP_NONE;
        ctrl.branch     = BR_NONE;
        ctrl.mem_read   = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.alu_src    = 1'b0;
        ctrl.reg_write  = 1'b0;
        ctrl.auipc      = 1'b0;
        ctrl.alu_op     = ALU_NOP;

        case (opcode)
            RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = arith_op(funct3, bit30);
            end
            ITYPER: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                // bit 30 of an immediate only selects srai
                ctrl.alu_op    = arith_op(funct3, bit30 & (funct3 == 3'b101));
            end
            ITYPEL: begin
                ctrl.width      = mem_width(funct3);
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_op     = ALU_ADD; // address
            end
            STYPE: begin
                ctrl.width     = mem_width(funct3);
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end
            UTYPE: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_LUI;
            end
            AUIPC: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.auipc     = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end
            SBTYPE: begin
                ctrl.alu_op = ALU_SUB; // flags only
                case (funct3)
                    3'b000:  ctrl.branch = BR_EQ;
                    3'b001:  ctrl.branch = BR_NE;
                    3'b100:  ctrl.branch = BR_LT;
                    3'b101:  ctrl.branch = BR_GE;
                    default: ctrl.branch = BR_NONE;
                endcase
            end
            ITYPEJ: begin
                ctrl.jump      = JMP_JALR;
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_ADD; // rs1 + imm target
            end
            JTYPE: begin
                ctrl.jump      = JMP_JAL;
                ctrl.reg_write = 1'b1;
            end
            default: begin
                ctrl.alu_op = ALU_NOP;
            end
        endcase
    end

endmodule

// ==== hdl/imm_gen.sv ====
/*
 * imm_gen
 * sign-extended immediate for the I, S, B, U and J formats
 */
`timescale 1ns/1ns

module imm_gen import rv32_pkg::*; (
    input  instr_u      instr,
    output logic [31:0] imm
);

    always_comb begin
        case (instr.r.opcode)
            ITYPEL, ITYPER, ITYPEJ: begin
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            STYPE: begin
                imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            SBTYPE: begin
                imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            end
            UTYPE, AUIPC: begin
                imm = {instr.u.imm, 12'b0};
            end
            JTYPE: begin
                imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                       instr.j.imm11, instr.j.imm10_1, 1'b0};
            end
            default: begin
                imm = 32'b0; // rtype has none
            end
        endcase
    end

endmodule

// ==== hdl/alu.sv ====
/*
 * alu
 * integer operations plus zero and signed less-than flags
 */
`timescale 1ns/1ns

module alu import rv32_pkg::*; (
    input  alu_op_e     op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result,
    output logic        zero,
    output logic        lt
);

    logic [31:0] diff;
    logic        ovf;

    assign diff = a - b;
    // signed overflow of a - b
    assign ovf  = (a[31] ^ b[31]) & (a[31] ^ diff[31]);
    assign zero = (diff == 32'b0);
    assign lt   = diff[31] ^ ovf;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = diff;
            ALU_SLL: result = a << b[4:0];
            ALU_SLT: result = {31'b0, lt};
            ALU_XOR: result = a ^ b;
            ALU_SRL: result = a >> b[4:0];
            ALU_SRA: result = $signed(a) >>> b[4:0];
            ALU_OR:  result = a | b;
            ALU_AND: result = a & b;
            ALU_LUI: result = b;
            default: result = 32'b0; // nop
        endcase
    end

endmodule

// ==== hdl/reg_file.sv ====
/*
 * reg_file
 * 32 x 32 registers, two async reads, one write, x0 reads zero
 */
`timescale 1ns/1ns

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= 32'b0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? 32'b0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? 32'b0 : regs[rs2];

endmodule

// ==== hdl/rv32_core.sv ====
/*
 * rv32_core
 * single-cycle RV32I core, one instruction per valid fetch,
 * each executed instruction reported as a retire record
 */
`timescale 1ns/1ns

module rv32_core import rv32_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_rdata,
    input  logic        fetch_valid,
    output dmem_req_t   dmem_req,
    input  logic [31:0] dmem_rdata,
    output retire_t     retire,
    output logic        retire_valid
);

    logic [31:0] pc;
    logic        run;       // first edge after reset release seen
    logic        exec;
    instr_u      instr;
    ctrl_t       ctrl;
    logic [31:0] imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic        alu_lt;
    logic        taken;
    logic [31:0] pc_plus4;
    logic [31:0] next_pc;
    logic [1:0]  offset;
    logic [31:0] load_word;
    logic [31:0] load_data;
    logic [31:0] wb_data;
    logic        rd_we;

    assign instr     = imem_rdata;
    assign exec      = fetch_valid & run;
    assign imem_addr = pc;
    assign pc_plus4  = pc + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run <= 1'b0;
            pc  <= RESET_PC;
        end else begin
            run <= 1'b1;
            if (exec) begin
                pc <= next_pc;
            end
        end
    end

    control_unit u_ctrl (
        .opcode (instr.r.opcode),
        .funct3 (instr.r.funct3),
        .bit30  (instr.r.funct7[5]),
        .ctrl   (ctrl)
    );

    imm_gen u_imm (
        .instr (instr),
        .imm   (imm)
    );

    reg_file u_rf (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (instr.r.rs1),
        .rs2    (instr.r.rs2),
        .rd     (instr.r.rd),
        .we     (exec & rd_we),
        .wdata  (wb_data),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    assign op_a = ctrl.auipc ? pc : rs1_data;
    assign op_b = ctrl.alu_src ? imm : rs2_data;

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result),
        .zero   (alu_zero),
        .lt     (alu_lt)
    );

    always_comb begin
        case (ctrl.branch)
            BR_EQ:   taken = alu_zero;
            BR_NE:   taken = !alu_zero;
            BR_LT:   taken = alu_lt;
            BR_GE:   taken = !alu_lt;
            default: taken = 1'b0;
        endcase
        case (ctrl.jump)
            JMP_JAL:  next_pc = pc + imm;
            JMP_JALR: next_pc = {alu_result[31:1], 1'b0};
            default:  next_pc = taken ? pc + imm : pc_plus4;
        endcase
    end

    // memory returns the whole word
    assign offset    = alu_result[1:0];
    assign load_word = dmem_rdata >> {offset, 3'b000};

    always_comb begin
        case (ctrl.width)
            WIDTH_B: load_data = {{24{load_word[7]}}, load_word[7:0]};
            WIDTH_H: load_data = {{16{load_word[15]}}, load_word[15:0]};
            default: load_data = dmem_rdata;
        endcase

        dmem_req.addr  = alu_result;
        dmem_req.wdata = rs2_data << {offset, 3'b000};
        case (ctrl.width)
            WIDTH_B: dmem_req.strb = 4'b0001 << offset;
            WIDTH_H: dmem_req.strb = 4'b0011 << offset;
            default: dmem_req.strb = 4'b1111;
        endcase
        dmem_req.read  = exec & ctrl.mem_read;
        dmem_req.write = exec & ctrl.mem_write;
    end

    always_comb begin
        if (ctrl.jump != JMP_NONE) begin
            wb_data = pc_plus4; // link
        end else if (ctrl.mem_to_reg) begin
            wb_data = load_data;
        end else begin
            wb_data = alu_result;
        end
    end

    assign rd_we = ctrl.reg_write & (instr.r.rd != 5'd0);

    assign retire.pc     = pc;
    assign retire.rd     = instr.r.rd;
    assign retire.wdata  = wb_data;
    assign retire.we     = rd_we;
    assign retire_valid  = exec;

endmodule

// ==== dv/rv32_core_checker.sv ====
/*
 * rv32_core_checker
 * protocol assertions on the core's fetch, data and retire ports
 */
`timescale 1ns/1ns

module rv32_core_checker import rv32_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        fetch_valid,
    input logic [31:0] imem_addr,
    input dmem_req_t   dmem_req,
    input retire_t     retire,
    input logic        retire_valid
);

    a_no_retire_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !fetch_valid |-> !retire_valid)
        else $error("retire while fetch_valid low");

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        imem_addr[1:0] == 2'b00)
        else $error("pc not word aligned");

    a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_req.read && dmem_req.write))
        else $error("read and write together");

    a_x0_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_valid && retire.rd == 5'd0) |-> !retire.we)
        else $error("retire writes x0");

endmodule

// ==== dv/rv32_model.svh ====
/*
 * rv32 reference model
 * ISA step function, stall LFSR and typed compare tasks for the testbench
 */
`ifndef RV32_MODEL_SVH
`define RV32_MODEL_SVH

logic [31:0] m_pc;
logic [31:0] m_regs [0:31];
logic [31:0] m_mem [0:63];
logic [15:0] lfsr_state = 16'd54;

// fibonacci lfsr with taps 16 14 13 11
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
        3'd0:    r = alt ? a - b : a + b;
        3'd1:    r = a << b[4:0];
        3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd4:    r = a ^ b;
        3'd5:    r = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

function automatic void rv32_step(output retire_t exp_r, output dmem_req_t exp_d);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] next;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [2:0]  f3;
    logic [1:0]  off;
    logic        wr;
    logic        take;
    w     = imem[m_pc[7:2]];
    f3    = w[14:12];
    a     = m_regs[w[19:15]];
    b     = m_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    next  = m_pc + 32'd4;
    wr    = 1'b0;
    res   = 32'b0;
    exp_d = '0;
    case (w[6:0])
        7'h33: begin
            wr  = 1'b1;
            res = alu_ref(f3, w[30], a, b);
        end
        7'h13: begin
            wr  = 1'b1;
            res = alu_ref(f3, w[30] && f3 == 3'd5, a, imm_i);
        end
        7'h03: begin
            addr = a + imm_i;
            off  = addr[1:0];
            word = m_mem[addr[7:2]] >> (8 * off);
            wr   = 1'b1;
            if (f3 == 3'd0) res = {{24{word[7]}}, word[7:0]};
            else if (f3 == 3'd1) res = {{16{word[15]}}, word[15:0]};
            else res = m_mem[addr[7:2]];
            exp_d.addr = addr;
            exp_d.read = 1'b1;
        end
        7'h23: begin
            addr = a + imm_s;
            off  = addr[1:0];
            exp_d.addr  = addr;
            exp_d.write = 1'b1;
            exp_d.wdata = b << (8 * off);
            if (f3 == 3'd0) exp_d.strb = 4'b0001 << off;
            else if (f3 == 3'd1) exp_d.strb = 4'b0011 << off;
            else exp_d.strb = 4'b1111;
            for (int k = 0; k < 4; k++) begin
                if (exp_d.strb[k]) m_mem[addr[7:2]][8*k +: 8] = exp_d.wdata[8*k +: 8];
            end
        end
        7'h63: begin
            case (f3)
                3'd0:    take = (a == b);
                3'd1:    take = (a != b);
                3'd4:    take = ($signed(a) < $signed(b));
                default: take = ($signed(a) >= $signed(b));
            endcase
            if (take) next = m_pc + imm_b;
        end
        7'h6f: begin
            wr   = 1'b1;
            res  = m_pc + 32'd4;
            next = m_pc + imm_j;
        end
        7'h67: begin
            wr   = 1'b1;
            res  = m_pc + 32'd4;
            next = (a + imm_i) & ~32'd1;
        end
        7'h37: begin
            wr  = 1'b1;
            res = imm_u;
        end
        7'h17: begin
            wr  = 1'b1;
            res = m_pc + imm_u;
        end
        default: wr = 1'b0;
    endcase
    exp_r.pc    = m_pc;
    exp_r.rd    = w[11:7];
    exp_r.wdata = res;
    exp_r.we    = wr && (w[11:7] != 5'd0);
    if (exp_r.we) m_regs[w[11:7]] = res;
    m_pc = next;
endfunction

task automatic compare_retire(input retire_t got, input retire_t exp);
    if (got.pc !== exp.pc) begin
        $display("mismatch t=%0t retire.pc got %h exp %h", $time, got.pc, exp.pc);
        mismatches++;
    end
    if (got.we !== exp.we || got.rd !== exp.rd) begin
        $display("mismatch t=%0t retire.rd/we got %0d/%b exp %0d/%b", $time,
                 got.rd, got.we, exp.rd, exp.we);
        mismatches++;
    end else if (exp.we && got.wdata !== exp.wdata) begin
        $display("mismatch t=%0t retire.wdata got %h exp %h", $time, got.wdata, exp.wdata);
        mismatches++;
    end
endtask

task automatic compare_dmem(input dmem_req_t got, input dmem_req_t exp);
    if (got.read !== exp.read || got.write !== exp.write) begin
        $display("mismatch t=%0t dmem_req.read/write got %b/%b exp %b/%b", $time,
                 got.read, got.write, exp.read, exp.write);
        mismatches++;
    end else if ((exp.read || exp.write) && got.addr !== exp.addr) begin
        $display("mismatch t=%0t dmem_req.addr got %h exp %h", $time, got.addr, exp.addr);
        mismatches++;
    end else if (exp.write && (got.strb !== exp.strb || got.wdata !== exp.wdata)) begin
        $display("mismatch t=%0t dmem_req.strb/wdata got %h/%h exp %h/%h", $time,
                 got.strb, got.wdata, exp.strb, exp.wdata);
        mismatches++;
    end
endtask

`endif

// ==== dv/rv32_core_tb.sv ====
/*
 * rv32_core testbench
 * assembles a program, runs it with random fetch stalls and checks
 * every retire and data access against the reference model
 */
`timescale 1ns/1ns

module rv32_core_tb import rv32_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        fetch_valid;
    dmem_req_t   dmem_req;
    logic [31:0] dmem_rdata;
    retire_t     retire;
    logic        retire_valid;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    int          n_prog;
    int          mismatches;
    int          other_errors;
    int          cycles;
    int          limit;
    logic [31:0] halt_pc;
    logic        done;
    logic        first_seen;
    retire_t     exp_r;
    dmem_req_t   exp_d;

    `include "rv32_model.svh"

    rv32_core #(.RESET_PC(32'h0)) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .fetch_valid  (fetch_valid),
        .dmem_req     (dmem_req),
        .dmem_rdata   (dmem_rdata),
        .retire       (retire),
        .retire_valid (retire_valid)
    );

    assign imem_rdata = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_req.addr[7:2]];

    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] imm, input int rs1,
                                          input int f3, input int rd, input logic [6:0] op);
        return {imm[11:0], 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [31:0] imm, input int rs2,
                                          input int rs1, input int f3);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] imm, input int rs2,
                                          input int rs1, input int f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[n_prog] = w;
        n_prog++;
    endtask

    task automatic load_program();
        for (int k = 0; k < 64; k++) begin
            imem[k] = enc_i(32'(k), 0, 0, 0, 7'h13); // addi x0 with index as imm
            dmem[k] = 32'(k) * 32'h01030507;        // word pattern from the index
            m_mem[k] = dmem[k];
        end
        n_prog = 0;
        emit(enc_i(5, 0, 0, 1, 7'h13));
        emit(enc_i(-3, 0, 0, 2, 7'h13));
        emit(enc_r(0, 2, 1, 0, 3));           // add
        emit(enc_r(32, 1, 2, 0, 4));          // sub
        emit(enc_r(0, 1, 1, 1, 5));           // sll
        emit(enc_r(0, 1, 2, 2, 6));           // slt
        emit(enc_r(0, 2, 1, 4, 7));
        emit(enc_r(0, 2, 1, 6, 8));
        emit(enc_r(0, 2, 1, 7, 9));
        emit(enc_r(32, 1, 4, 5, 10));         // sra negative
        emit(enc_r(0, 1, 4, 5, 11));
        emit(enc_i(32'h401, 2, 5, 12, 7'h13)); // srai
        emit(enc_i(3, 1, 1, 13, 7'h13));
        emit(enc_i(-1, 1, 4, 14, 7'h13));
        emit(enc_i(-4, 2, 2, 15, 7'h13));
        emit(enc_i(7, 1, 0, 0, 7'h13));       // write to x0
        emit({20'h12345, 5'd14, 7'h37});      // lui
        emit({20'h00010, 5'd15, 7'h17});      // auipc
        emit(enc_i(64, 0, 0, 16, 7'h13));
        emit(enc_s(0, 4, 16, 2));
        emit(enc_s(5, 1, 16, 0));
        emit(enc_s(10, 2, 16, 1));
        emit(enc_i(0, 16, 2, 17, 7'h03));
        emit(enc_i(5, 16, 0, 18, 7'h03));
        emit(enc_i(10, 16, 1, 19, 7'h03));
        emit(enc_i(2, 16, 0, 20, 7'h03));
        emit(enc_i(2, 16, 1, 21, 7'h03));
        emit(enc_b(8, 1, 1, 0));              // beq taken
        emit(enc_i(1, 0, 0, 22, 7'h13));
        emit(enc_b(8, 1, 1, 1));              // bne not taken
        emit(enc_i(2, 22, 0, 22, 7'h13));
        emit(enc_b(8, 1, 2, 4));              // blt taken
        emit(enc_i(3, 0, 0, 22, 7'h13));
        emit(enc_b(8, 1, 2, 5));              // bge not taken
        emit(enc_i(4, 0, 0, 23, 7'h13));
        emit(enc_b(8, 2, 1, 5));              // bge taken
        emit(enc_i(5, 0, 0, 23, 7'h13));
        emit(enc_b(8, 2, 1, 4));              // blt not taken
        emit(enc_j(8, 24));
        emit(enc_i(6, 0, 0, 24, 7'h13));
        emit({20'h0, 5'd25, 7'h17});
        emit(enc_i(13, 25, 0, 26, 7'h67));    // odd target loses bit 0
        emit(enc_i(1, 0, 0, 27, 7'h13));
        emit(enc_i(2, 0, 0, 28, 7'h13));
        halt_pc = 32'(n_prog * 4);
        emit(enc_j(0, 0));                    // spin here
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (dmem_req.write) begin
            for (int k = 0; k < 4; k++) begin
                if (dmem_req.strb[k]) begin
                    dmem[dmem_req.addr[7:2]][8*k +: 8] <= dmem_req.wdata[8*k +: 8];
                end
            end
        end
    end

    always @(negedge clk) begin
        fetch_valid = !(lfsr_bit() & lfsr_bit()); // about one stall in four
    end

    always @(posedge clk) begin
        if (!rst_n && (retire_valid || dmem_req.write)) begin
            $display("retire or store seen while reset is asserted at t=%0t", $time);
            other_errors++;
        end else if (rst_n && !fetch_valid && retire_valid) begin
            $display("retire during a fetch stall at t=%0t", $time);
            other_errors++;
        end else if (rst_n && !retire_valid && (dmem_req.read || dmem_req.write)) begin
            $display("memory access without a retire at t=%0t", $time);
            other_errors++;
        end else if (rst_n && retire_valid && !done) begin
            if (!first_seen && retire.pc !== 32'h0) begin
                $display("first retire not at the reset pc, pc %h", retire.pc);
                other_errors++;
            end
            first_seen = 1'b1;
            rv32_step(exp_r, exp_d);
            compare_retire(retire, exp_r);
            compare_dmem(dmem_req, exp_d);
            if (exp_r.pc == halt_pc) done = 1'b1;
        end
    end

    initial begin
        rst_n        = 1'b0;
        fetch_valid  = 1'b1;
        mismatches   = 0;
        other_errors = 0;
        cycles       = 0;
        done         = 1'b0;
        first_seen   = 1'b0;
        m_pc         = 32'h0;
        for (int k = 0; k < 32; k++) m_regs[k] = 32'b0;
        load_program();
        limit = n_prog * 4 + 50;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while (!done && cycles < limit) @(posedge clk);
        if (!done) begin
            $display("timeout, halt address not reached after %0d cycles", cycles);
            other_errors++;
        end
        $display("checks done, %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

bind rv32_core rv32_core_checker chk0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_valid  (fetch_valid),
    .imem_addr    (imem_addr),
    .dmem_req     (dmem_req),
    .retire       (retire),
    .retire_valid (retire_valid)
);

// ==== rv32_core.f ====
+incdir+dv
hdl/rv32_pkg.sv
hdl/control_unit.sv
hdl/imm_gen.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/rv32_core.sv
dv/rv32_core_checker.sv
dv/rv32_core_tb.sv

// ==== Makefile ====
# Verilator build and run for rv32_core

VERILATOR ?= verilator
TOP       ?= rv32_core_tb
FLIST     ?= rv32_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
